// File: Makefile
# Verilator build and run for the SCSI DMA controller testbench

VERILATOR ?= verilator
TOP       ?= sdmacTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The run fails unless the pass line shows up in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF -- "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
verilog/sdmacPkg.sv
verilog/datapathInput.sv
verilog/datapathOutput.sv
verilog/datapathScsi.sv
verilog/datapath.sv
verilog/transferFifo.sv
verilog/controlRegs.sv
verilog/sdmacTop.sv
sim/sdmacTb.sv

// File: sim/sdmacTb.sv
// Testbench for the SCSI DMA controller top level
// Directed transfers through the FIFO, SCSI and register paths, with
// concurrent assertions comparing the ports against a model of the rules
module sdmacTb;
    timeunit 1ns;
    timeprecision 100ps;

    // Cycles a flag may take to reach its level
    localparam int FlagTimeout = 20;

    logic                           clk;
    logic                           arstN;
    sdmacPkg::cpuBusT               cpuBus;
    logic [sdmacPkg::DataWidth-1:0] dataIn;
    sdmacPkg::steerT                steer;
    sdmacPkg::laneT                 lane;
    logic [sdmacPkg::ScsiWidth-1:0] pdIn;
    logic                           dieH;
    logic                           dieL;
    logic                           bridgeIn;
    logic                           bridgeOut;
    logic                           fifoWr;
    logic                           fifoRd;
    logic                           regWr;
    logic [sdmacPkg::DataWidth-1:0] dataOut;
    logic                           dataOe;
    logic [sdmacPkg::ScsiWidth-1:0] pdOut;
    logic                           fifoFull;
    logic                           fifoEmpty;

    // Expected values, armed by the stimulus for one sampling edge
    logic                           checkData;
    logic [sdmacPkg::DataWidth-1:0] expData;
    logic                           checkPd;
    logic [sdmacPkg::ScsiWidth-1:0] expPd;

    // Model of the latched CPU word, the direction bit and the FIFO occupancy
    logic [sdmacPkg::DataWidth-1:0] modelMid;
    logic                           modelDir;
    int                             modelCount;
    logic                           modelOe;

    int     errors;
    int     checks;
    int     testsDone;
    int     testStart;
    integer seed = 25;
    logic   timedOut;
    string  timeoutWhat;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    sdmacTop i_sdmacTop (
        .clk       (clk),
        .arstN     (arstN),
        .cpuBus    (cpuBus),
        .dataIn    (dataIn),
        .steer     (steer),
        .lane      (lane),
        .pdIn      (pdIn),
        .dieH      (dieH),
        .dieL      (dieL),
        .bridgeIn  (bridgeIn),
        .bridgeOut (bridgeOut),
        .fifoWr    (fifoWr),
        .fifoRd    (fifoRd),
        .regWr     (regWr),
        .dataOut   (dataOut),
        .dataOe    (dataOe),
        .pdOut     (pdOut),
        .fifoFull  (fifoFull),
        .fifoEmpty (fifoEmpty)
    );

    // A CPU write latches the bus, a register write takes that latched word,
    // and each push or pop pulse moves the occupancy on its edge
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            modelMid   <= '0;
            modelDir   <= 1'b0;
            modelCount <= 0;
        end else begin
            if (!cpuBus.dsN && !cpuBus.rw) begin
                modelMid <= dataIn;
            end
            if (regWr && cpuBus.addr == sdmacPkg::regCntr) begin
                modelDir <= modelMid[1];
            end
            if (fifoWr && !fifoRd) begin
                modelCount <= modelCount + 1;
            end else if (fifoRd && !fifoWr) begin
                modelCount <= modelCount - 1;
            end
        end
    end

    // Selected CPU read, or DMA owning the bus toward memory
    assign modelOe = (!cpuBus.dsN && !cpuBus.dmacSelN && cpuBus.rw) || (!cpuBus.ownN && modelDir);

    dataOutCheck: assert property (@(posedge clk) disable iff (!arstN)
        checkData |-> dataOut == expData)
        else begin
            errors = errors + 1;
            $display("Error at %0t ns: dataOut expected %h actual %h",
                     $time, $sampled(expData), $sampled(dataOut));
        end

    pdOutCheck: assert property (@(posedge clk) disable iff (!arstN)
        checkPd |-> pdOut == expPd)
        else begin
            errors = errors + 1;
            $display("Error at %0t ns: pdOut expected %h actual %h",
                     $time, $sampled(expPd), $sampled(pdOut));
        end

    dataOeCheck: assert property (@(posedge clk) disable iff (!arstN) dataOe == modelOe)
        else begin
            errors = errors + 1;
            $display("Error at %0t ns: dataOe expected %b actual %b",
                     $time, $sampled(modelOe), $sampled(dataOe));
        end

    emptyCheck: assert property (@(posedge clk) disable iff (!arstN)
        fifoEmpty == (modelCount == 0))
        else begin
            errors = errors + 1;
            $display("Error at %0t ns: fifoEmpty expected %b actual %b",
                     $time, $sampled(modelCount) == 0, $sampled(fifoEmpty));
        end

    fullCheck: assert property (@(posedge clk) disable iff (!arstN)
        fifoFull == (modelCount == sdmacPkg::FifoDepth))
        else begin
            errors = errors + 1;
            $display("Error at %0t ns: fifoFull expected %b actual %b",
                     $time, $sampled(modelCount) == sdmacPkg::FifoDepth, $sampled(fifoFull));
        end

    // Ends the run once a wait has given up
    initial begin
        wait (timedOut === 1'b1);
        $display("Timeout: %s never reached the awaited level", timeoutWhat);
        $display("=== FAIL ===");
        $finish;
    end

    function automatic logic [sdmacPkg::DataWidth-1:0] randWord();
        return $random(seed);
    endfunction

    function automatic logic flagLevel(input bit useFull);
        return useFull ? fifoFull : fifoEmpty;
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic driveIdle();
        cpuBus.dsN      = 1'b1;
        cpuBus.dmacSelN = 1'b1;
        cpuBus.rw       = 1'b1;
        cpuBus.ownN     = 1'b1;
        cpuBus.addr     = sdmacPkg::regCntr;
        dataIn    = '0;
        steer     = '0;
        lane      = '0;
        pdIn      = '0;
        dieH      = 1'b1;
        dieL      = 1'b1;
        bridgeIn  = 1'b0;
        bridgeOut = 1'b0;
        fifoWr    = 1'b0;
        fifoRd    = 1'b0;
        regWr     = 1'b0;
        checkData = 1'b0;
        expData   = '0;
        checkPd   = 1'b0;
        expPd     = '0;
    endtask

    // After a timeout this process stalls and the watcher above ends the run
    task automatic waitFlag(input bit useFull, input bit level);
        int cycles;
        cycles = 0;
        while (flagLevel(useFull) != level && cycles < FlagTimeout) begin
            tick();
            cycles++;
        end
        if (flagLevel(useFull) != level) begin
            timeoutWhat = useFull ? "fifoFull" : "fifoEmpty";
            timedOut = 1'b1;
            forever tick();
        end
    endtask

    task automatic cpuWrite(input sdmacPkg::regAddrE addr, input logic [31:0] word,
                            input logic hi, input logic lo, input logic bridge);
        cpuBus.addr     = addr;
        cpuBus.dmacSelN = 1'b0;
        cpuBus.dsN      = 1'b0;
        cpuBus.rw       = 1'b0;
        dataIn   = word;
        dieH     = hi;
        dieL     = lo;
        bridgeIn = bridge;
        tick();
        cpuBus.dsN      = 1'b1;
        cpuBus.dmacSelN = 1'b1;
        cpuBus.rw       = 1'b1;
        dieH     = 1'b1;
        dieL     = 1'b1;
        bridgeIn = 1'b0;
    endtask

    // The address stays on the bus through the write pulse
    task automatic regWrite(input sdmacPkg::regAddrE addr, input logic [31:0] word);
        cpuWrite(addr, word, 1'b1, 1'b1, 1'b0);
        regWr = 1'b1;
        tick();
        regWr = 1'b0;
    endtask

    task automatic pushWord();
        fifoWr = 1'b1;
        tick();
        fifoWr = 1'b0;
        waitFlag(1'b0, 1'b0);
    endtask

    task automatic popWord();
        fifoRd = 1'b1;
        tick();
        fifoRd = 1'b0;
    endtask

    // One SCSI half-word, packed under s2f or under the CPU latch strobe
    task automatic scsiHalf(input logic [15:0] half, input logic a3, input logic latch);
        pdIn    = half;
        lane.a3 = a3;
        if (latch) begin
            steer.ls2cpu = 1'b1;
        end else begin
            steer.s2f = 1'b1;
        end
        tick();
        steer.ls2cpu = 1'b0;
        steer.s2f    = 1'b0;
    endtask

    task automatic expectData(input logic [31:0] value);
        expData   = value;
        checkData = 1'b1;
        checks++;
        tick();
        checkData = 1'b0;
    endtask

    task automatic expectPd(input logic [15:0] value);
        expPd   = value;
        checkPd = 1'b1;
        checks++;
        tick();
        checkPd = 1'b0;
    endtask

    // Both halves from the FIFO head, registered on the next edge
    task automatic checkHead(input logic [31:0] value, input logic bridge);
        steer.f2cpuL = 1'b1;
        steer.f2cpuH = 1'b1;
        bridgeOut    = bridge;
        tick();
        expectData(value);
        steer.f2cpuL = 1'b0;
        steer.f2cpuH = 1'b0;
        bridgeOut    = 1'b0;
    endtask

    task automatic transferCheck(input logic [31:0] value, input logic bridge);
        pushWord();
        checkHead(value, bridge);
        popWord();
        waitFlag(1'b0, 1'b1);
    endtask

    task automatic finishTest(input string name);
        testsDone++;
        $display("Test %0d %s finished with %0d errors", testsDone, name, errors - testStart);
    endtask

    task automatic testScsiToCpu();
        logic [31:0] word;
        testStart = errors;
        word = randWord();
        scsiHalf(word[31:16], 1'b0, 1'b0);
        scsiHalf(word[15:0], 1'b1, 1'b0);
        // The push edge repacks the same low half, so the word is unchanged
        steer.s2f = 1'b1;
        transferCheck(word, 1'b0);
        steer.s2f = 1'b0;
        finishTest("SCSI to FIFO to CPU");
    endtask

    task automatic testCpuToScsi();
        logic [31:0] word;
        testStart = errors;
        word = randWord();
        cpuWrite(sdmacPkg::regCntr, word, 1'b1, 1'b1, 1'b0);
        pushWord();
        steer.f2s = 1'b1;
        tick();
        expectPd(word[31:16]);
        lane.bo1 = 1'b1;
        tick();
        expectPd(word[15:0]);
        lane.bo1 = 1'b0;
        lane.bo0 = 1'b1;
        tick();
        expectPd({word[23:16], word[31:24]});
        steer.f2s = 1'b0;
        lane      = '0;
        popWord();
        waitFlag(1'b0, 1'b1);
        finishTest("CPU to FIFO to SCSI");
    endtask

    task automatic testRegisters();
        logic [31:0] word;
        testStart = errors;
        word = randWord();
        regWrite(sdmacPkg::regScratch, word);
        tick();
        expectData(word);
        // Direction toward memory drives the bus while DMA owns it
        regWrite(sdmacPkg::regCntr, 32'h2);
        cpuBus.ownN = 1'b0;
        repeat (2) tick();
        cpuBus.ownN = 1'b1;
        tick();
        regWrite(sdmacPkg::regCntr, 32'h0);
        // CPU read with and without the chip select
        cpuBus.dsN = 1'b0;
        cpuBus.rw  = 1'b1;
        repeat (2) tick();
        cpuBus.dmacSelN = 1'b0;
        repeat (2) tick();
        cpuBus.dsN      = 1'b1;
        cpuBus.dmacSelN = 1'b1;
        cpuBus.addr     = sdmacPkg::regIstr;
        tick();
        expectData(32'h1);
        regWrite(sdmacPkg::regIstr, 32'hffff_fffc);
        tick();
        expectData(32'h1);
        finishTest("registers and output enable");
    endtask

    task automatic testBridging();
        logic [31:0] word;
        logic [31:0] old;
        testStart = errors;
        word = randWord();
        cpuWrite(sdmacPkg::regCntr, word, 1'b1, 1'b1, 1'b1);
        transferCheck({word[15:0], word[15:0]}, 1'b0);
        word = randWord();
        cpuWrite(sdmacPkg::regCntr, word, 1'b1, 1'b1, 1'b0);
        transferCheck({word[31:16], word[31:16]}, 1'b1);
        // Only the low lane moves on the second write
        old  = randWord();
        word = randWord();
        cpuWrite(sdmacPkg::regCntr, old, 1'b1, 1'b1, 1'b0);
        cpuWrite(sdmacPkg::regCntr, word, 1'b0, 1'b1, 1'b0);
        transferCheck({old[31:16], word[15:0]}, 1'b0);
        finishTest("bridging and lanes");
    endtask

    task automatic testFlagsAndLatch();
        logic [31:0] pushed [$];
        logic [31:0] word;
        logic [31:0] other;
        int          i;
        testStart = errors;
        for (i = 0; i < sdmacPkg::FifoDepth; i++) begin
            word = randWord();
            pushed.push_back(word);
            cpuWrite(sdmacPkg::regCntr, word, 1'b1, 1'b1, 1'b0);
            pushWord();
        end
        waitFlag(1'b1, 1'b1);
        cpuBus.addr = sdmacPkg::regIstr;
        tick();
        expectData(32'h2);
        for (i = 0; i < sdmacPkg::FifoDepth; i++) begin
            checkHead(pushed[i], 1'b0);
            popWord();
        end
        waitFlag(1'b0, 1'b1);
        // Pack a word, latch it, then overwrite the packer with new halves
        word  = randWord();
        other = randWord();
        scsiHalf(word[31:16], 1'b0, 1'b0);
        scsiHalf(word[15:0], 1'b1, 1'b0);
        scsiHalf(word[15:0], 1'b1, 1'b1);
        scsiHalf(other[31:16], 1'b0, 1'b0);
        scsiHalf(other[15:0], 1'b1, 1'b0);
        steer.s2cpu = 1'b1;
        tick();
        expectData(word);
        steer.s2cpu = 1'b0;
        finishTest("FIFO flags and SCSI latch");
    endtask

    initial begin
        timedOut  = 1'b0;
        errors    = 0;
        checks    = 0;
        testsDone = 0;
        testStart = 0;
        arstN     = 1'b0;
        driveIdle();
        repeat (3) @(posedge clk);
        #1;
        arstN = 1'b1;
        tick();
        testScsiToCpu();
        testCpuToScsi();
        testRegisters();
        testBridging();
        testFlagsAndLatch();
        $display("Tests %0d, checks %0d, errors %0d", testsDone, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: verilog/controlRegs.sv
// Control and status registers on the CPU bus
// Holds the control word with the DMA direction bit, a scratch word,
// and a read-only status word built from the FIFO flags
module controlRegs (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           wr,
    input  sdmacPkg::regAddrE              addr,
    input  logic [sdmacPkg::DataWidth-1:0] din,
    input  logic                           fifoFull,
    input  logic                           fifoEmpty,
    output logic [sdmacPkg::DataWidth-1:0] dout,
    output logic                           dmaDir
);

    logic [sdmacPkg::DataWidth-1:0] cntr;
    logic [sdmacPkg::DataWidth-1:0] scratch;
    logic [sdmacPkg::DataWidth-1:0] istr;

    // Bit 1 of the control word sets the transfer toward memory
    assign dmaDir = cntr[1];

    // Status word, empty in bit 0 and full in bit 1
    assign istr = {{(sdmacPkg::DataWidth - 2){1'b0}}, fifoFull, fifoEmpty};

    // Writes land on the edge after the pulse, the status word ignores them
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cntr    <= '0;
            scratch <= '0;
        end else if (wr) begin
            case (addr)
                sdmacPkg::regCntr:    cntr <= din;
                sdmacPkg::regScratch: scratch <= din;
                default: ;
            endcase
        end
    end

    // Read mux is combinational from the address
    always_comb begin
        case (addr)
            sdmacPkg::regCntr:    dout = cntr;
            sdmacPkg::regIstr:    dout = istr;
            sdmacPkg::regScratch: dout = scratch;
            default:              dout = '0;
        endcase
    end

    // The address comes from the CPU bus bundle and must decode on every write
    legalWrAddr: assert property (@(posedge clk) disable iff (!arstN)
        wr |-> (addr inside {sdmacPkg::regCntr, sdmacPkg::regIstr, sdmacPkg::regScratch}))
        else $error("controlRegs: write to undecoded address %0d", addr);

endmodule

// File: verilog/datapath.sv
// SCSI DMA data path
// Steers words between the CPU bus, the transfer FIFO and the SCSI port,
// and decides when this chip drives the CPU data bus
module datapath (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic [sdmacPkg::DataWidth-1:0] dataIn,
    input  logic [sdmacPkg::ScsiWidth-1:0] pdIn,
    input  logic [sdmacPkg::DataWidth-1:0] fifoOd,
    input  logic [sdmacPkg::DataWidth-1:0] regOd,
    input  sdmacPkg::cpuBusT               cpuBus,
    input  sdmacPkg::steerT                steer,
    input  sdmacPkg::laneT                 lane,
    input  logic                           dmaDir,
    input  logic                           bridgeIn,
    input  logic                           bridgeOut,
    input  logic                           dieH,
    input  logic                           dieL,
    output logic [sdmacPkg::ScsiWidth-1:0] pdOut,
    output logic [sdmacPkg::DataWidth-1:0] mid,
    output logic [sdmacPkg::DataWidth-1:0] fifoId,
    output logic [sdmacPkg::DataWidth-1:0] dataOut,
    output logic                           dataOe
);

    logic [sdmacPkg::DataWidth-1:0] cpuOd;
    logic [sdmacPkg::DataWidth-1:0] scsiOd;
    logic [sdmacPkg::DataWidth-1:0] modScsi;
    logic [sdmacPkg::DataWidth-1:0] modTx;
    logic                           dieLow;

    // CPU to SCSI always uses the low lanes
    assign dieLow = dieL | steer.cpu2s;

    // The CPU reads either the latched SCSI word or a register
    assign modTx = steer.s2cpu ? modScsi : regOd;

    // The FIFO fills from SCSI during s2f and from the CPU otherwise
    assign fifoId = steer.s2f ? scsiOd : cpuOd;

    // Drive the bus on a selected CPU read, or when DMA owns the bus heading to memory
    assign dataOe = (~cpuBus.dsN & ~cpuBus.dmacSelN & cpuBus.rw) | (~cpuBus.ownN & dmaDir);

    datapathInput u_datapathInput (
        .clk      (clk),
        .arstN    (arstN),
        .data     (dataIn),
        .cpuBus   (cpuBus),
        .bridgeIn (bridgeIn),
        .dieH     (dieH),
        .dieL     (dieLow),
        .mid      (mid),
        .cpuOd    (cpuOd)
    );

    datapathOutput u_datapathOutput (
        .clk       (clk),
        .arstN     (arstN),
        .od        (fifoOd),
        .mod       (modTx),
        .f2cpuL    (steer.f2cpuL),
        .f2cpuH    (steer.f2cpuH),
        .bridgeOut (bridgeOut),
        .data      (dataOut)
    );

    datapathScsi u_datapathScsi (
        .clk     (clk),
        .arstN   (arstN),
        .pdIn    (pdIn),
        .fifoOd  (fifoOd),
        .cpuOd   (cpuOd),
        .steer   (steer),
        .lane    (lane),
        .pdOut   (pdOut),
        .scsiOd  (scsiOd),
        .modScsi (modScsi)
    );

endmodule

// File: verilog/datapathInput.sv
// CPU-side input latch of the data path
// Captures write data into the register path and into the
// word bound for the FIFO or SCSI, with lane enables and 16-bit bridging
module datapathInput (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic [sdmacPkg::DataWidth-1:0] data,
    input  sdmacPkg::cpuBusT               cpuBus,
    input  logic                           bridgeIn,
    input  logic                           dieH,
    input  logic                           dieL,
    output logic [sdmacPkg::DataWidth-1:0] mid,
    output logic [sdmacPkg::DataWidth-1:0] cpuOd
);

    localparam int Half = sdmacPkg::DataWidth / 2;

    logic                           cpuWrite;
    logic [sdmacPkg::DataWidth-1:0] bridged;

    // A CPU write cycle is a low data strobe with the bus in write direction
    assign cpuWrite = ~cpuBus.dsN & ~cpuBus.rw;

    // A 16-bit master drives only the low lanes, so mirror them upward
    assign bridged = bridgeIn ? {data[Half-1:0], data[Half-1:0]} : data;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mid   <= '0;
            cpuOd <= '0;
        end else if (cpuWrite) begin
            // The register path always sees the raw bus
            mid <= data;
            // Each half of the transfer word only moves when its lane is enabled
            if (dieH) begin
                cpuOd[sdmacPkg::DataWidth-1:Half] <= bridged[sdmacPkg::DataWidth-1:Half];
            end
            if (dieL) begin
                cpuOd[Half-1:0] <= bridged[Half-1:0];
            end
        end
    end

endmodule

// File: verilog/datapathOutput.sv
// CPU-side output register of the data path
// Each half comes from the FIFO head or from the modified word,
// and a 16-bit reader gets the high half copied into the low lanes
module datapathOutput (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic [sdmacPkg::DataWidth-1:0] od,
    input  logic [sdmacPkg::DataWidth-1:0] mod,
    input  logic                           f2cpuL,
    input  logic                           f2cpuH,
    input  logic                           bridgeOut,
    output logic [sdmacPkg::DataWidth-1:0] data
);

    localparam int Half = sdmacPkg::DataWidth / 2;

    logic [Half-1:0] highSel;
    logic [Half-1:0] lowSel;
    logic [Half-1:0] lowOut;

    // Per-half source selection
    assign highSel = f2cpuH ? od[sdmacPkg::DataWidth-1:Half] : mod[sdmacPkg::DataWidth-1:Half];
    assign lowSel  = f2cpuL ? od[Half-1:0] : mod[Half-1:0];

    // A 16-bit reader only looks at the low lanes, so it must see the high half there
    assign lowOut = bridgeOut ? highSel : lowSel;

    // The register follows its source every cycle, so a stable source
    // shows on the bus one cycle later
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            data <= '0;
        end else begin
            data <= {highSel, lowOut};
        end
    end

endmodule

// File: verilog/datapathScsi.sv
// SCSI side of the data path
// Packs incoming SCSI half-words into a 32-bit word, splits
// FIFO or CPU words back into half-words for the SCSI port, and
// holds a latched copy of the packed word for the CPU
module datapathScsi (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic [sdmacPkg::ScsiWidth-1:0] pdIn,
    input  logic [sdmacPkg::DataWidth-1:0] fifoOd,
    input  logic [sdmacPkg::DataWidth-1:0] cpuOd,
    input  sdmacPkg::steerT                steer,
    input  sdmacPkg::laneT                 lane,
    output logic [sdmacPkg::ScsiWidth-1:0] pdOut,
    output logic [sdmacPkg::DataWidth-1:0] scsiOd,
    output logic [sdmacPkg::DataWidth-1:0] modScsi
);

    localparam int Byte = sdmacPkg::ScsiWidth / 2;

    logic                           packEn;
    logic                           sendEn;
    logic [sdmacPkg::DataWidth-1:0] txWord;
    logic [sdmacPkg::ScsiWidth-1:0] txHalf;
    logic [sdmacPkg::ScsiWidth-1:0] txSwapped;

    // Incoming half-words are captured both for the FIFO and for the CPU latch
    assign packEn = steer.s2f | steer.ls2cpu;
    assign sendEn = steer.f2s | steer.cpu2s;

    // Outgoing source word, FIFO head unless the CPU is writing straight to SCSI
    assign txWord = steer.f2s ? fifoOd : cpuOd;

    // bo1 low selects the high half, which goes out first
    assign txHalf = lane.bo1 ? txWord[sdmacPkg::ScsiWidth-1:0]
                             : txWord[sdmacPkg::DataWidth-1:sdmacPkg::ScsiWidth];

    // bo0 swaps the byte order within the chosen half
    assign txSwapped = lane.bo0 ? {txHalf[Byte-1:0], txHalf[sdmacPkg::ScsiWidth-1:Byte]}
                                : txHalf;

    // Packer, a3 picks which half of the word this half-word fills
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            scsiOd <= '0;
        end else if (packEn) begin
            if (lane.a3) begin
                scsiOd[sdmacPkg::ScsiWidth-1:0] <= pdIn;
            end else begin
                scsiOd[sdmacPkg::DataWidth-1:sdmacPkg::ScsiWidth] <= pdIn;
            end
        end
    end

    // The CPU latch takes the packed word as it stood before this edge,
    // so later half-words do not disturb what the CPU reads back
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            modScsi <= '0;
        end else if (steer.ls2cpu) begin
            modScsi <= scsiOd;
        end
    end

    // Registered SCSI output, held between transfers
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pdOut <= '0;
        end else if (sendEn) begin
            pdOut <= txSwapped;
        end
    end

    // The sequencer never sources SCSI from FIFO and CPU at once
    oneTxSource: assert property (@(posedge clk) disable iff (!arstN)
        !(steer.f2s && steer.cpu2s))
        else $error("datapathScsi: f2s and cpu2s both high");

endmodule

// File: verilog/sdmacPkg.sv
// SCSI DMA controller shared definitions
// Bus widths, FIFO geometry, register addresses and the
// packed control bundles that travel between the blocks
package sdmacPkg;

    // CPU bus and FIFO word width
    localparam int DataWidth = 32;

    // SCSI port width, one half of a CPU word
    localparam int ScsiWidth = 16;

    // Transfer FIFO geometry
    localparam int FifoDepth = 8;
    localparam int FifoAddrWidth = 3;

    // Register file addresses as seen on the CPU bus
    typedef enum logic [1:0] {
        regCntr    = 2'd0,
        regIstr    = 2'd1,
        regScratch = 2'd2
    } regAddrE;

    // Steering strobes from the DMA sequencer
    // All of them are level signals sampled on the clock edge
    typedef struct packed {
        logic cpu2s;
        logic s2cpu;
        logic s2f;
        logic f2s;
        logic ls2cpu;
        logic f2cpuL;
        logic f2cpuH;
    } steerT;

    // Half and byte offsets for the SCSI packer and unpacker
    typedef struct packed {
        // Low fills the high half of the packed word, high fills the low half
        logic a3;
        // Low sends the high half out on SCSI
        logic bo1;
        // High swaps the two bytes of the outgoing half
        logic bo0;
    } laneT;

    // CPU bus control, strobes are active low
    typedef struct packed {
        logic    dsN;
        logic    dmacSelN;
        logic    rw;
        logic    ownN;
        regAddrE addr;
    } cpuBusT;

endpackage

// File: verilog/sdmacTop.sv
// SCSI DMA controller top level
// Joins the data path with the transfer FIFO and the register file,
// sequencer strobes arrive as plain inputs
module sdmacTop (
    input  logic                           clk,
    input  logic                           arstN,
    input  sdmacPkg::cpuBusT               cpuBus,
    input  logic [sdmacPkg::DataWidth-1:0] dataIn,
    input  sdmacPkg::steerT                steer,
    input  sdmacPkg::laneT                 lane,
    input  logic [sdmacPkg::ScsiWidth-1:0] pdIn,
    input  logic                           dieH,
    input  logic                           dieL,
    input  logic                           bridgeIn,
    input  logic                           bridgeOut,
    input  logic                           fifoWr,
    input  logic                           fifoRd,
    input  logic                           regWr,
    output logic [sdmacPkg::DataWidth-1:0] dataOut,
    output logic                           dataOe,
    output logic [sdmacPkg::ScsiWidth-1:0] pdOut,
    output logic                           fifoFull,
    output logic                           fifoEmpty
);

    logic [sdmacPkg::DataWidth-1:0] fifoId;
    logic [sdmacPkg::DataWidth-1:0] fifoOd;
    logic [sdmacPkg::DataWidth-1:0] mid;
    logic [sdmacPkg::DataWidth-1:0] regOd;
    logic                           dmaDir;

    datapath u_datapath (
        .clk       (clk),
        .arstN     (arstN),
        .dataIn    (dataIn),
        .pdIn      (pdIn),
        .fifoOd    (fifoOd),
        .regOd     (regOd),
        .cpuBus    (cpuBus),
        .steer     (steer),
        .lane      (lane),
        .dmaDir    (dmaDir),
        .bridgeIn  (bridgeIn),
        .bridgeOut (bridgeOut),
        .dieH      (dieH),
        .dieL      (dieL),
        .pdOut     (pdOut),
        .mid       (mid),
        .fifoId    (fifoId),
        .dataOut   (dataOut),
        .dataOe    (dataOe)
    );

    transferFifo u_transferFifo (
        .clk   (clk),
        .arstN (arstN),
        .wr    (fifoWr),
        .rd    (fifoRd),
        .din   (fifoId),
        .dout  (fifoOd),
        .full  (fifoFull),
        .empty (fifoEmpty)
    );

    // Register writes take the latched CPU word
    controlRegs u_controlRegs (
        .clk       (clk),
        .arstN     (arstN),
        .wr        (regWr),
        .addr      (cpuBus.addr),
        .din       (mid),
        .fifoFull  (fifoFull),
        .fifoEmpty (fifoEmpty),
        .dout      (regOd),
        .dmaDir    (dmaDir)
    );

endmodule

// File: verilog/transferFifo.sv
// Eight-word transfer FIFO
// First-word fall-through circular buffer, the head entry is always on dout
// and the flags follow the occupancy count
module transferFifo (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           wr,
    input  logic                           rd,
    input  logic [sdmacPkg::DataWidth-1:0] din,
    output logic [sdmacPkg::DataWidth-1:0] dout,
    output logic                           full,
    output logic                           empty
);

    localparam int CountWidth = sdmacPkg::FifoAddrWidth + 1;

    logic [sdmacPkg::DataWidth-1:0]     mem [sdmacPkg::FifoDepth];
    logic [sdmacPkg::FifoAddrWidth-1:0] wrPtr;
    logic [sdmacPkg::FifoAddrWidth-1:0] rdPtr;
    logic [CountWidth-1:0]              count;
    logic                               doWr;
    logic                               doRd;

    // Overflow and underflow requests are dropped rather than corrupting the pointers
    assign doWr = wr & ~full;
    assign doRd = rd & ~empty;

    // The flags come straight off the count, so they move with the pointers
    assign full  = (count == CountWidth'(sdmacPkg::FifoDepth));
    assign empty = (count == '0);

    // Head of the queue, valid one cycle after a push into an empty FIFO
    assign dout = mem[rdPtr];

    // Storage array
    always_ff @(posedge clk) begin
        if (doWr) begin
            mem[wrPtr] <= din;
        end
    end

    // Pointers wrap on their own at the power-of-two depth
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWr) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRd) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (doWr && !doRd) begin
                count <= count + 1'b1;
            end else if (doRd && !doWr) begin
                count <= count - 1'b1;
            end
        end
    end

    noPushFull: assert property (@(posedge clk) disable iff (!arstN) wr |-> !full)
        else $error("transferFifo: push while full");

    noPopEmpty: assert property (@(posedge clk) disable iff (!arstN) rd |-> !empty)
        else $error("transferFifo: pop while empty");

endmodule
